// File: hdl/rv_exec_pkg.sv
// shared widths, opcodes and stage bus structs for the RV64 execute slice and its testbench
`default_nettype none

package rv_exec_pkg;

  localparam int unsigned XLEN          = 64;
  localparam int unsigned WORD_WD       = 32;  // word-cut operand width
  localparam int unsigned PC_WD         = 64;
  localparam int unsigned GPR_ADDR_WD   = 5;
  localparam int unsigned CSR_ADDR_WD   = 12;
  localparam int unsigned SRAM_ADDR_WD  = 32;
  localparam int unsigned SRAM_WMASK_WD = 8;   // one enable per byte lane

  typedef enum logic [4:0] {
    ALU_ADD   = 5'd0,
    ALU_SUB   = 5'd1,
    ALU_SLL   = 5'd2,
    ALU_SLT   = 5'd3,
    ALU_SLTU  = 5'd4,
    ALU_XOR   = 5'd5,
    ALU_SRL   = 5'd6,
    ALU_SRA   = 5'd7,
    ALU_OR    = 5'd8,
    ALU_AND   = 5'd9,
    ALU_PASS2 = 5'd10  // lui
  } alu_op_e;

  typedef enum logic {
    SRC1_RS1 = 1'b0,
    SRC1_PC  = 1'b1
  } src1_sel_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2  // link address for jal/jalr
  } src2_sel_e;

  // low two bits give the access size
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  typedef enum logic [2:0] {
    CSR_NONE = 3'd0,
    CSR_RW   = 3'd1,
    CSR_RS   = 3'd2,
    CSR_RC   = 3'd3,
    CSR_RWI  = 3'd4,
    CSR_RSI  = 3'd5,
    CSR_RCI  = 3'd6
  } csr_op_e;

  // decode to execute, 359 bits
  typedef struct packed {
    logic [XLEN-1:0]        rs1data;
    logic [XLEN-1:0]        rs2data;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        imm;       // zimm sits in imm[4:0] for csr*i
    logic [PC_WD-1:0]       pc;
    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    logic                   word_cut;  // *w instructions
    alu_op_e                alu_op;
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    logic                   mem_wen;
    mem_op_e                mem_op;
    logic                   csr_inst;  // gpr gets csrrdata
    csr_op_e                csr_op;
    logic                   ebreak;
    logic                   invalid;
  } ds_to_es_t;

  // execute to memory
  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [CSR_ADDR_WD-1:0] csr;
    logic                   gpr_wen;
    logic                   csr_wen;
    logic                   mem_ren;
    mem_op_e                mem_op;    // load alignment happens in mem stage
    logic                   csr_inst;
    logic [XLEN-1:0]        csrrdata;
    logic [XLEN-1:0]        alu_result;
    logic [XLEN-1:0]        csr_result;
  } es_to_ms_t;

  typedef struct packed {
    logic [SRAM_ADDR_WD-1:0]  addr;
    logic                     ren;     // read data returns in mem stage
    logic                     wen;
    logic [SRAM_WMASK_WD-1:0] wmask;
    logic [XLEN-1:0]          wdata;
  } sram_req_t;

endpackage

`default_nettype wire

// File: hdl/pipe_reg.sv
// stage boundary register for any payload type, with valid that clears on flush
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire      i_clk,
  input  wire      i_arst_n,
  input  wire      i_flush,   // kills the entry being captured
  input  wire      i_valid,
  input  payload_t i_data,
  output logic     o_valid,
  output payload_t o_data
);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid & ~i_flush;
    end
  end

  // payload loads every cycle, consumers look at o_valid
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_data <= '0;
    end else begin
      o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// File: hdl/exu.sv
// execute unit with operand select, 64-bit ALU with word cut and CSR new-value arithmetic
`timescale 1ns/1ns
`default_nettype none

module exu (
  input  rv_exec_pkg::ds_to_es_t          i_op,
  output logic [rv_exec_pkg::XLEN-1:0]    o_alu_result,
  output logic [rv_exec_pkg::XLEN-1:0]    o_csr_result
);

  logic [rv_exec_pkg::XLEN-1:0]    src1;
  logic [rv_exec_pkg::XLEN-1:0]    src2;
  logic [rv_exec_pkg::WORD_WD-1:0] src1_w;    // low words for *w ops
  logic [rv_exec_pkg::WORD_WD-1:0] src2_w;
  logic [5:0]                      shamt;
  logic [rv_exec_pkg::XLEN-1:0]    alu_raw;   // before word cut
  logic [rv_exec_pkg::XLEN-1:0]    csr_src;   // rs1 or zimm

  // operand select
  always_comb begin
    if (i_op.src1_sel == rv_exec_pkg::SRC1_PC) begin
      src1 = i_op.pc;
    end else begin
      src1 = i_op.rs1data;
    end
  end

  always_comb begin
    case (i_op.src2_sel)
      rv_exec_pkg::SRC2_IMM:  src2 = i_op.imm;
      rv_exec_pkg::SRC2_FOUR: src2 = 64'd4;   // pc + 4 link
      default:                src2 = i_op.rs2data;
    endcase
  end

  assign src1_w = src1[rv_exec_pkg::WORD_WD-1:0];
  assign src2_w = src2[rv_exec_pkg::WORD_WD-1:0];

  // word ops shift by 5 bits only
  assign shamt = i_op.word_cut ? {1'b0, src2[4:0]} : src2[5:0];

  always_comb begin
    case (i_op.alu_op)
      rv_exec_pkg::ALU_ADD:  alu_raw = src1 + src2;
      rv_exec_pkg::ALU_SUB:  alu_raw = src1 - src2;
      rv_exec_pkg::ALU_SLL:  alu_raw = src1 << shamt;
      rv_exec_pkg::ALU_SLT: begin
        if (i_op.word_cut) begin
          alu_raw = {{(rv_exec_pkg::XLEN-1){1'b0}}, $signed(src1_w) < $signed(src2_w)};
        end else begin
          alu_raw = {{(rv_exec_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
        end
      end
      rv_exec_pkg::ALU_SLTU: begin
        if (i_op.word_cut) begin
          alu_raw = {{(rv_exec_pkg::XLEN-1){1'b0}}, src1_w < src2_w};
        end else begin
          alu_raw = {{(rv_exec_pkg::XLEN-1){1'b0}}, src1 < src2};
        end
      end
      rv_exec_pkg::ALU_XOR:  alu_raw = src1 ^ src2;
      rv_exec_pkg::ALU_SRL: begin
        // srlw must not pull upper bits into the word
        if (i_op.word_cut) begin
          alu_raw = {{rv_exec_pkg::WORD_WD{1'b0}}, src1_w >> shamt};
        end else begin
          alu_raw = src1 >> shamt;
        end
      end
      rv_exec_pkg::ALU_SRA: begin
        if (i_op.word_cut) begin
          alu_raw = {{rv_exec_pkg::WORD_WD{src1_w[31]}}, $signed(src1_w) >>> shamt};
        end else begin
          alu_raw = $signed(src1) >>> shamt;
        end
      end
      rv_exec_pkg::ALU_OR:    alu_raw = src1 | src2;
      rv_exec_pkg::ALU_AND:   alu_raw = src1 & src2;
      rv_exec_pkg::ALU_PASS2: alu_raw = src2;  // lui
      default:                alu_raw = '0;
    endcase
  end

  // word cut keeps 32 bits and sign-extends them
  always_comb begin
    if (i_op.word_cut) begin
      o_alu_result = {{rv_exec_pkg::WORD_WD{alu_raw[31]}},
                      alu_raw[rv_exec_pkg::WORD_WD-1:0]};
    end else begin
      o_alu_result = alu_raw;
    end
  end

  // csr*i take the zero-extended 5-bit zimm
  always_comb begin
    case (i_op.csr_op)
      rv_exec_pkg::CSR_RWI,
      rv_exec_pkg::CSR_RSI,
      rv_exec_pkg::CSR_RCI: csr_src = {{(rv_exec_pkg::XLEN-5){1'b0}}, i_op.imm[4:0]};
      default:              csr_src = i_op.rs1data;
    endcase
  end

  always_comb begin
    case (i_op.csr_op)
      rv_exec_pkg::CSR_RW,
      rv_exec_pkg::CSR_RWI: o_csr_result = csr_src;
      rv_exec_pkg::CSR_RS,
      rv_exec_pkg::CSR_RSI: o_csr_result = i_op.csrrdata | csr_src;   // set bits
      rv_exec_pkg::CSR_RC,
      rv_exec_pkg::CSR_RCI: o_csr_result = i_op.csrrdata & ~csr_src;  // clear bits
      default:              o_csr_result = i_op.csrrdata;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/lsu_store.sv
// store lane formatting, builds the byte mask and lane-shifted data for sb/sh/sw/sd
`timescale 1ns/1ns
`default_nettype none

module lsu_store (
  input  rv_exec_pkg::mem_op_e                 i_mem_op,
  input  wire  [2:0]                           i_waddr_align,  // addr[2:0]
  input  wire  [rv_exec_pkg::XLEN-1:0]         i_wdata,
  output logic [rv_exec_pkg::SRAM_WMASK_WD-1:0] o_wmask,
  output logic [rv_exec_pkg::XLEN-1:0]         o_wdata
);

  logic [rv_exec_pkg::SRAM_WMASK_WD-1:0] base_mask;  // mask at offset 0
  logic [rv_exec_pkg::XLEN-1:0]          repl_data;

  // only the size matters for stores
  always_comb begin
    case (i_mem_op)
      rv_exec_pkg::MEM_B,
      rv_exec_pkg::MEM_BU: begin
        base_mask = 8'h01;
        repl_data = {8{i_wdata[7:0]}};
      end
      rv_exec_pkg::MEM_H,
      rv_exec_pkg::MEM_HU: begin
        base_mask = 8'h03;
        repl_data = {4{i_wdata[15:0]}};
      end
      rv_exec_pkg::MEM_W,
      rv_exec_pkg::MEM_WU: begin
        base_mask = 8'h0f;
        repl_data = {2{i_wdata[31:0]}};
      end
      default: begin   // sd
        base_mask = 8'hff;
        repl_data = i_wdata;
      end
    endcase
  end

  // misaligned lanes past byte 7 just fall off
  assign o_wmask = base_mask << i_waddr_align;

  // shift moves the low copy onto the first enabled lane
  assign o_wdata = repl_data << {i_waddr_align, 3'b000};

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
// combinational execute stage joining exu and lsu_store, issues the data SRAM request
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
  input  wire                     i_valid,
  input  rv_exec_pkg::ds_to_es_t  i_ds_to_es,
  output rv_exec_pkg::es_to_ms_t  o_es_to_ms,
  output rv_exec_pkg::sram_req_t  o_data_sram,
  output logic                    o_halt,     // ebreak or illegal
  output logic                    o_illegal
);

  logic [rv_exec_pkg::XLEN-1:0]          alu_result;
  logic [rv_exec_pkg::XLEN-1:0]          csr_result;
  logic [rv_exec_pkg::SRAM_WMASK_WD-1:0] st_wmask;
  logic [rv_exec_pkg::XLEN-1:0]          st_wdata;

  exu u_exu (
    .i_op         (i_ds_to_es),
    .o_alu_result (alu_result),
    .o_csr_result (csr_result)
  );

  lsu_store u_lsu_store (
    .i_mem_op      (i_ds_to_es.mem_op),
    .i_waddr_align (alu_result[2:0]),     // rs1 + imm
    .i_wdata       (i_ds_to_es.rs2data),  // store source
    .o_wmask       (st_wmask),
    .o_wdata       (st_wdata)
  );

  // request goes out from execute, data comes back in mem
  always_comb begin
    o_data_sram.addr  = alu_result[rv_exec_pkg::SRAM_ADDR_WD-1:0];
    o_data_sram.ren   = i_ds_to_es.mem_ren & i_valid;
    o_data_sram.wen   = i_ds_to_es.mem_wen & i_valid;
    o_data_sram.wmask = st_wmask;
    o_data_sram.wdata = st_wdata;
  end

  assign o_halt    = i_valid & (i_ds_to_es.ebreak | i_ds_to_es.invalid);
  assign o_illegal = i_valid & i_ds_to_es.invalid;

  always_comb begin
    o_es_to_ms.rd         = i_ds_to_es.rd;
    o_es_to_ms.csr        = i_ds_to_es.csr;
    o_es_to_ms.gpr_wen    = i_ds_to_es.gpr_wen;
    o_es_to_ms.csr_wen    = i_ds_to_es.csr_wen;
    o_es_to_ms.mem_ren    = i_ds_to_es.mem_ren;
    o_es_to_ms.mem_op     = i_ds_to_es.mem_op;
    o_es_to_ms.csr_inst   = i_ds_to_es.csr_inst;
    o_es_to_ms.csrrdata   = i_ds_to_es.csrrdata;  // old csr value for rd
    o_es_to_ms.alu_result = alu_result;
    o_es_to_ms.csr_result = csr_result;
  end

endmodule

`default_nettype wire

// File: hdl/ex_core.sv
// execute slice top, input register then execute stage then output register
`timescale 1ns/1ns
`default_nettype none

module ex_core (
  input  wire                     i_clk,
  input  wire                     i_arst_n,
  input  wire                     i_flush,
  input  wire                     i_ds_valid,
  input  rv_exec_pkg::ds_to_es_t  i_ds_to_es,
  output rv_exec_pkg::sram_req_t  o_data_sram,
  output logic                    o_halt,
  output logic                    o_illegal,
  output logic                    o_es_valid,
  output rv_exec_pkg::es_to_ms_t  o_es_to_ms
);

  rv_exec_pkg::ds_to_es_t ds_to_es_q;   // registered decode bus
  logic                   es_valid;
  rv_exec_pkg::es_to_ms_t es_to_ms;

  pipe_reg #(.payload_t(rv_exec_pkg::ds_to_es_t)) u_ds_es_reg (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_flush  (i_flush),      // flush only hits the entering instruction
    .i_valid  (i_ds_valid),
    .i_data   (i_ds_to_es),
    .o_valid  (es_valid),
    .o_data   (ds_to_es_q)
  );

  ex_stage u_ex_stage (
    .i_valid     (es_valid),
    .i_ds_to_es  (ds_to_es_q),
    .o_es_to_ms  (es_to_ms),
    .o_data_sram (o_data_sram),
    .o_halt      (o_halt),
    .o_illegal   (o_illegal)
  );

  pipe_reg #(.payload_t(rv_exec_pkg::es_to_ms_t)) u_es_ms_reg (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_flush  (1'b0),
    .i_valid  (es_valid),
    .i_data   (es_to_ms),
    .o_valid  (o_es_valid),
    .o_data   (o_es_to_ms)
  );

endmodule

`default_nettype wire

// File: tb/tb_ex_core.sv
// table-driven testbench for the execute slice that checks the sram request, halt pulses and mem bus
`timescale 1ns/1ns
`default_nettype none

module tb_ex_core;

  typedef struct {
    rv_exec_pkg::ds_to_es_t op;
    logic                   valid;
    logic                   flush;
    rv_exec_pkg::sram_req_t exp_sram;
    rv_exec_pkg::es_to_ms_t exp_ms;
    logic                   exp_halt;
    logic                   exp_illegal;
    logic                   exp_valid;
  } entry_t;

  logic                   clk;
  logic                   arst_n;
  logic                   flush;
  logic                   ds_valid;
  rv_exec_pkg::ds_to_es_t ds_to_es;
  rv_exec_pkg::sram_req_t data_sram;
  logic                   halt;
  logic                   illegal;
  logic                   es_valid;
  rv_exec_pkg::es_to_ms_t es_to_ms;

  entry_t tbl[$];
  string  names[$];
  bit     bad[$];      // set per entry by either stage
  int     seed = 32'h3ddd;
  int     err_cnt = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     cycles = 0;
  int     limit = 0;   // set once the table is built

  ex_core i_dut (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_flush     (flush),
    .i_ds_valid  (ds_valid),
    .i_ds_to_es  (ds_to_es),
    .o_data_sram (data_sram),
    .o_halt      (halt),
    .o_illegal   (illegal),
    .o_es_valid  (es_valid),
    .o_es_to_ms  (es_to_ms)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [63:0] alu_model(input rv_exec_pkg::ds_to_es_t t);
    logic [63:0] a;
    logic [63:0] b;
    logic [31:0] aw;
    logic [31:0] bw;
    logic [31:0] rw;
    logic [63:0] r;
    a = (t.src1_sel == rv_exec_pkg::SRC1_PC) ? t.pc : t.rs1data;
    case (t.src2_sel)
      rv_exec_pkg::SRC2_IMM:  b = t.imm;
      rv_exec_pkg::SRC2_FOUR: b = 64'd4;
      default:                b = t.rs2data;
    endcase
    if (t.word_cut) begin
      // word mode works on 32-bit operands only
      aw = a[31:0];
      bw = b[31:0];
      case (t.alu_op)
        rv_exec_pkg::ALU_ADD:  rw = aw + bw;
        rv_exec_pkg::ALU_SUB:  rw = aw - bw;
        rv_exec_pkg::ALU_SLL:  rw = aw << bw[4:0];
        rv_exec_pkg::ALU_SLT:  rw = {31'd0, $signed(aw) < $signed(bw)};
        rv_exec_pkg::ALU_SLTU: rw = {31'd0, aw < bw};
        rv_exec_pkg::ALU_XOR:  rw = aw ^ bw;
        rv_exec_pkg::ALU_SRL:  rw = aw >> bw[4:0];
        rv_exec_pkg::ALU_SRA:  rw = $signed(aw) >>> bw[4:0];
        rv_exec_pkg::ALU_OR:   rw = aw | bw;
        rv_exec_pkg::ALU_AND:  rw = aw & bw;
        default:               rw = bw;  // pass src2
      endcase
      r = {{32{rw[31]}}, rw};
    end else begin
      case (t.alu_op)
        rv_exec_pkg::ALU_ADD:  r = a + b;
        rv_exec_pkg::ALU_SUB:  r = a - b;
        rv_exec_pkg::ALU_SLL:  r = a << b[5:0];
        rv_exec_pkg::ALU_SLT:  r = {63'd0, $signed(a) < $signed(b)};
        rv_exec_pkg::ALU_SLTU: r = {63'd0, a < b};
        rv_exec_pkg::ALU_XOR:  r = a ^ b;
        rv_exec_pkg::ALU_SRL:  r = a >> b[5:0];
        rv_exec_pkg::ALU_SRA:  r = $signed(a) >>> b[5:0];
        rv_exec_pkg::ALU_OR:   r = a | b;
        rv_exec_pkg::ALU_AND:  r = a & b;
        default:               r = b;
      endcase
    end
    return r;
  endfunction

  function automatic logic [63:0] csr_model(input rv_exec_pkg::ds_to_es_t t);
    logic [63:0] s;
    s = (t.csr_op >= rv_exec_pkg::CSR_RWI) ? {59'd0, t.imm[4:0]} : t.rs1data;
    case (t.csr_op)
      rv_exec_pkg::CSR_RW, rv_exec_pkg::CSR_RWI: return s;
      rv_exec_pkg::CSR_RS, rv_exec_pkg::CSR_RSI: return t.csrrdata | s;
      rv_exec_pkg::CSR_RC, rv_exec_pkg::CSR_RCI: return t.csrrdata & ~s;
      default:                                   return t.csrrdata;
    endcase
  endfunction

  function automatic rv_exec_pkg::sram_req_t sram_model(input rv_exec_pkg::ds_to_es_t t,
                                                       input logic alive);
    rv_exec_pkg::sram_req_t req;
    logic [63:0]            alu;
    int                     off;
    int                     nbytes;
    int                     i;
    alu = alu_model(t);
    off = alu[2:0];
    nbytes = 1 << t.mem_op[1:0];
    req.addr  = alu[31:0];
    req.ren   = t.mem_ren & alive;
    req.wen   = t.mem_wen & alive;
    req.wmask = '0;
    req.wdata = '0;
    for (i = 0; i < 8; i++) begin
      if (i >= off) begin  // lane i carries store byte (i - off) mod size
        req.wdata[8*i +: 8] = t.rs2data[8*((i - off) % nbytes) +: 8];
        req.wmask[i] = (i < off + nbytes);
      end
    end
    return req;
  endfunction

  function automatic rv_exec_pkg::ds_to_es_t rand_op();
    rv_exec_pkg::ds_to_es_t t;
    t = '0;
    t.rs1data  = {$random(seed), $random(seed)};
    t.rs2data  = {$random(seed), $random(seed)};
    t.csrrdata = {$random(seed), $random(seed)};
    t.imm      = {$random(seed), $random(seed)};
    t.pc       = {$random(seed), $random(seed)};
    t.rd       = $random(seed);
    t.csr      = $random(seed);
    return t;
  endfunction

  task automatic add_entry(input string name, input rv_exec_pkg::ds_to_es_t op,
                           input logic valid_in, input logic flush_in);
    entry_t e;
    logic   alive;
    alive = valid_in & ~flush_in;
    e.op          = op;
    e.valid       = valid_in;
    e.flush       = flush_in;
    e.exp_sram    = sram_model(op, alive);
    e.exp_halt    = alive & (op.ebreak | op.invalid);
    e.exp_illegal = alive & op.invalid;
    e.exp_valid   = alive;
    e.exp_ms.rd         = op.rd;
    e.exp_ms.csr        = op.csr;
    e.exp_ms.gpr_wen    = op.gpr_wen;
    e.exp_ms.csr_wen    = op.csr_wen;
    e.exp_ms.mem_ren    = op.mem_ren;
    e.exp_ms.mem_op     = op.mem_op;
    e.exp_ms.csr_inst   = op.csr_inst;
    e.exp_ms.csrrdata   = op.csrrdata;
    e.exp_ms.alu_result = alu_model(op);
    e.exp_ms.csr_result = csr_model(op);
    tbl.push_back(e);
    names.push_back(name);
    bad.push_back(1'b0);
  endtask

  task automatic build_table();
    rv_exec_pkg::ds_to_es_t t;
    int                     n;
    int                     wc;
    int                     op;
    int                     sz;
    int                     off;
    n = 0;
    for (wc = 0; wc < 2; wc++) begin
      for (op = 0; op <= 10; op++) begin
        t = rand_op();
        t.alu_op   = rv_exec_pkg::alu_op_e'(op);
        t.word_cut = wc[0];
        t.src1_sel = rv_exec_pkg::src1_sel_e'(n % 2);  // rotates all six selections
        t.src2_sel = rv_exec_pkg::src2_sel_e'(n % 3);
        t.gpr_wen  = 1'b1;
        add_entry($sformatf("alu op %0d word %0d", op, wc), t, 1'b1, 1'b0);
        n++;
      end
    end
    for (op = 0; op <= 6; op++) begin
      t = rand_op();
      t.csr_op   = rv_exec_pkg::csr_op_e'(op);
      t.csr_inst = 1'b1;
      t.csr_wen  = (op != 0);
      t.gpr_wen  = 1'b1;
      add_entry($sformatf("csr op %0d", op), t, 1'b1, 1'b0);
    end
    for (sz = 0; sz < 4; sz++) begin
      for (off = 0; off < 8; off++) begin
        t = rand_op();
        t.src2_sel     = rv_exec_pkg::SRC2_IMM;
        t.rs1data[2:0] = 3'd0;
        t.imm          = off;  // address offset lands in addr[2:0]
        t.mem_wen      = 1'b1;
        t.mem_op = rv_exec_pkg::mem_op_e'((sz < 3 && off[0]) ? sz + 4 : sz);
        add_entry($sformatf("store size %0d offset %0d", sz, off), t, 1'b1, 1'b0);
      end
    end
    for (op = 0; op <= 6; op++) begin
      t = rand_op();
      t.src2_sel = rv_exec_pkg::SRC2_IMM;
      t.imm      = {{52{t.imm[11]}}, t.imm[11:0]};
      t.mem_ren  = 1'b1;
      t.gpr_wen  = 1'b1;
      t.mem_op   = rv_exec_pkg::mem_op_e'(op);
      add_entry($sformatf("load op %0d", op), t, 1'b1, 1'b0);
    end
    t = rand_op();
    t.mem_wen = 1'b1;
    add_entry("flushed store", t, 1'b1, 1'b1);
    t = rand_op();
    t.mem_ren = 1'b1;
    add_entry("load without valid", t, 1'b0, 1'b0);
    t = rand_op();
    t.ebreak = 1'b1;
    add_entry("ebreak", t, 1'b1, 1'b0);
    add_entry("add after ebreak", rand_op(), 1'b1, 1'b0);
    t = rand_op();
    t.invalid = 1'b1;
    add_entry("illegal", t, 1'b1, 1'b0);
    t = rand_op();
    t.ebreak = 1'b1;
    add_entry("flushed ebreak", t, 1'b1, 1'b1);
    add_entry("final add", rand_op(), 1'b1, 1'b0);
  endtask

  task automatic check_sram(input rv_exec_pkg::sram_req_t act,
                            input rv_exec_pkg::sram_req_t exp, input string what);
    logic ok;
    ok = (act.ren === exp.ren) && (act.wen === exp.wen);
    if (exp.ren || exp.wen) ok = ok && (act.addr === exp.addr);
    if (exp.wen) ok = ok && (act.wmask === exp.wmask) && (act.wdata === exp.wdata);
    if (!ok) begin
      $display("error at %0t: %s sram got %h expected %h", $time, what, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_es_to_ms(input rv_exec_pkg::es_to_ms_t act,
                                input rv_exec_pkg::es_to_ms_t exp, input string what);
    if (act !== exp) begin
      $display("error at %0t: %s es_to_ms got %h expected %h", $time, what, act, exp);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("error at %0t: %s got %b expected %b", $time, what, act, exp);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input bit ok);
    if (ok) pass_cnt++;
    else fail_cnt++;
    $display("test %s: %s", name, ok ? "ok" : "fail");
  endtask

  initial begin
    int k;
    int snap;
    arst_n   = 1'b0;
    flush    = 1'b0;
    ds_valid = 1'b0;
    ds_to_es = '0;
    build_table();
    limit = tbl.size() + 5 + 20;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    snap = err_cnt;
    check_flag(data_sram.ren, 1'b0, "ren after reset");
    check_flag(data_sram.wen, 1'b0, "wen after reset");
    check_flag(halt, 1'b0, "halt after reset");
    check_flag(illegal, 1'b0, "illegal after reset");
    check_flag(es_valid, 1'b0, "es valid after reset");
    report_test("reset idle", err_cnt == snap);
    // request and halt show one edge after input and the mem bus two edges after
    for (k = 0; k < tbl.size() + 2; k++) begin
      if (k >= 1 && k - 1 < tbl.size()) begin
        snap = err_cnt;
        check_sram(data_sram, tbl[k-1].exp_sram, names[k-1]);
        check_flag(halt, tbl[k-1].exp_halt, {names[k-1], " halt"});
        check_flag(illegal, tbl[k-1].exp_illegal, {names[k-1], " illegal"});
        if (err_cnt != snap) bad[k-1] = 1'b1;
      end
      if (k >= 2) begin
        snap = err_cnt;
        check_flag(es_valid, tbl[k-2].exp_valid, {names[k-2], " es valid"});
        if (tbl[k-2].exp_valid) check_es_to_ms(es_to_ms, tbl[k-2].exp_ms, names[k-2]);
        if (err_cnt != snap) bad[k-2] = 1'b1;
        report_test(names[k-2], !bad[k-2]);
      end
      if (k < tbl.size()) begin
        ds_to_es = tbl[k].op;
        ds_valid = tbl[k].valid;
        flush    = tbl[k].flush;
      end else begin
        ds_valid = 1'b0;  // drain
        flush    = 1'b0;
      end
      @(negedge clk);
    end
    $display("tests: %0d ok, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/rv_exec_pkg.sv
hdl/pipe_reg.sv
hdl/exu.sv
hdl/lsu_store.sv
hdl/ex_stage.sv
hdl/ex_core.sv
tb/tb_ex_core.sv

// File: Bender.yml
package:
  name: rv_exec_slice

dependencies: {}

sources:
  - hdl/rv_exec_pkg.sv
  - hdl/pipe_reg.sv
  - hdl/exu.sv
  - hdl/lsu_store.sv
  - hdl/ex_stage.sv
  - hdl/ex_core.sv
  - target: test
    files:
      - tb/tb_ex_core.sv
